//--- knight_pkg.sv
// Shared types and constants for the knight robot command processor.
// Holds the command opcodes, the sequencer states, the datapath widths
// and the ramp, nudge and alignment constants used by the RTL and the
// testbench. Modules import it inside their bodies.

package knight_pkg;

  ////////////////////////////////////////
  // Command and state encodings
  ////////////////////////////////////////

  // Opcode field cmd[15:12]; unknown values fall through to MOV.
  typedef enum logic [3:0] {
    CAL     = 4'h2,                        // Gyro calibration.
    MOV     = 4'h4,                        // Plain move.
    FANFARE = 4'h5,                        // Move, then play the charge tune.
    TOUR    = 4'h6                         // Kick off the knight's tour.
  } opcode_t;

  typedef enum logic [2:0] {
    IDLE,                                  // Waiting for cmd_rdy.
    CALIBRATE,                             // Waiting for cal_done.
    MOVE,                                  // Turning to the new heading.
    INCR,                                  // Ramping up, counting lines.
    DECR                                   // Ramping down to a stop.
  } state_t;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  typedef logic signed [11:0] heading_t;   // Gyro heading and PID error.
  typedef logic        [9:0]  speed_t;     // Forward speed.
  typedef logic        [3:0]  square_t;    // Squares to travel.
  typedef logic        [7:0]  head_code_t; // Heading field cmd[11:4].

  ////////////////////////////////////////
  // Tuning constants
  ////////////////////////////////////////

  localparam speed_t          INC_AMT      = 10'h020; // Ramp-up step per heading_rdy.
  localparam speed_t          DEC_AMT      = 10'h040; // Ramp-down step, floored at zero.
  localparam heading_t        NUDGE_LFT    = 12'sh1FF; // Left IR pushes error positive.
  localparam heading_t        NUDGE_RGHT   = -12'sh200; // Right IR pushes it negative.
  localparam logic [11:0]     ALIGN_THRESH = 12'h02C; // Aligned below this |error|.
  localparam logic [3:0]      HEAD_FILL    = 4'hF;    // Low nibble for nonzero codes.

endpackage

//--- move_if.sv
// Bundle between the command sequencer and the two move helpers.
// The sequencer loads the square count and heading code, and gets
// back the line-count completion and the heading alignment levels.

interface move_if;
  import knight_pkg::*;

  logic       load;      // One-cycle pulse on MOV or FANFARE accept.
  square_t    squares;   // Requested square count.
  head_code_t head_code; // Requested heading code.
  logic       move_done; // Twice the squares crossed.
  logic       aligned;   // |error| under threshold.

  modport seq (
    output load, squares, head_code,
    input  move_done, aligned
  );

  modport counter (input load, squares, output move_done);

  modport steer (input load, head_code, output aligned);

endinterface

//--- heading_ctrl.sv
// Heading side of a move. Captures the desired heading on load,
// forms the PID error from the gyro heading and the side IR nudge,
// and reports when the robot points close enough to the target.

module heading_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  move_if.steer              mv,
  input  knight_pkg::heading_t heading,  // From gyro.
  input  logic               lftIR,      // Drifted toward left edge.
  input  logic               rghtIR,     // Drifted toward right edge.
  output knight_pkg::heading_t error     // To PID.
);
  import knight_pkg::*;

  heading_t    desired_heading;          // Target heading of the move.
  heading_t    err_nudge;                // Side sensor correction.
  logic [11:0] error_abs;                // Magnitude for the align test.

  ////////////////////////////////////////
  // Desired heading capture
  ////////////////////////////////////////

  // Code 0 means north exactly and other codes get the fill nibble.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      desired_heading <= '0;                                // North until the first move.
    else if (mv.load) begin
      if (mv.head_code == head_code_t'(0))
        desired_heading <= '0;                              // Straight north.
      else
        desired_heading <= heading_t'({mv.head_code, HEAD_FILL}); // Scaled code.
    end
  end

  ////////////////////////////////////////
  // Error and alignment
  ////////////////////////////////////////

  // Left IR wins if both sensors fire.
  assign err_nudge = lftIR  ? NUDGE_LFT  :
                     rghtIR ? NUDGE_RGHT :
                              heading_t'(0);

  assign error = heading - desired_heading + err_nudge; // Wraps like the gyro.

  assign error_abs = error[11] ? 12'(-error) : 12'(error); // Two's complement abs.

  assign mv.aligned = (error_abs < ALIGN_THRESH);          // Close enough to drive.

endmodule

//--- line_counter.sv
// Counts center-line crossings during a move. Each square gives two
// rising edges on cntrIR, so the move is done when the edge count
// reaches twice the requested squares. Cleared by the load pulse.

module line_counter (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  cntrIR,   // Center IR, high over a line.
  move_if.counter mv
);
  import knight_pkg::*;

  logic       cntrIR_q;   // Last cycle's cntrIR.
  logic       line_rise;  // Just reached a line.
  logic [4:0] cross_cnt;  // Edges seen so far, up to 30.
  square_t    target;     // Squares for this move.

  ////////////////////////////////////////
  // Edge detect and counter
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cntrIR_q <= 1'b0;
    else
      cntrIR_q <= cntrIR;                  // Delay for edge detect.
  end

  assign line_rise = cntrIR & ~cntrIR_q;   // Low to high.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cross_cnt <= '0;
    else if (mv.load)
      cross_cnt <= '0;                     // New move starts at zero.
    else if (line_rise)
      cross_cnt <= cross_cnt + 5'd1;       // One more edge.
  end

  always_ff @(posedge clk) begin
    if (mv.load)
      target <= mv.squares;                // Hold the request.
  end

  // Level, stays high until the next load.
  assign mv.move_done = (cross_cnt == {target, 1'b0});

endmodule

//--- cmd_sequencer.sv
// Command FSM of the knight robot. Accepts a command in IDLE, runs
// gyro calibration or a tour kick-off, or steps a move through
// MOVE, INCR and DECR while ramping the forward speed register.
// The accepted command is latched since clr_cmd_rdy frees the source.

module cmd_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [15:0]        cmd,         // Opcode, heading code, squares.
  input  logic               cmd_rdy,     // Command waiting.
  input  logic               cal_done,    // Gyro calibration finished.
  input  logic               heading_rdy, // New gyro sample, ramp tick.
  move_if.seq                mv,
  output logic               clr_cmd_rdy, // Command taken.
  output logic               send_resp,   // Command finished.
  output logic               strt_cal,    // Start gyro calibration.
  output logic               moving,      // Robot in motion.
  output logic               tour_go,     // Start the tour logic.
  output logic               fanfare_go,  // Start the fanfare tune.
  output knight_pkg::speed_t frwrd        // Forward speed to motors.
);
  import knight_pkg::*;

  state_t      state;         // Current state.
  state_t      nxt_state;     // Next state.
  logic [15:0] cmd_q;         // Accepted command.
  logic [15:0] cmd_cur;       // Live in IDLE, latched otherwise.
  opcode_t     opcode;        // Decoded opcode.
  logic        accept;        // Taking a command this cycle.
  logic        clr_frwrd;     // Restart the ramp.
  logic        inc_frwrd;     // Ramp up on heading_rdy.
  logic        dec_frwrd;     // Ramp down on heading_rdy.
  logic        max_spd;       // Top two speed bits set.
  logic        zero;          // Stopped.

  ////////////////////////////////////////
  // Command latch and decode
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept)
      cmd_q <= cmd;                           // Hold for the whole command.
  end

  // Bypass the latch in IDLE so the load sees the new command.
  assign cmd_cur = (state == IDLE) ? cmd : cmd_q;
  assign opcode  = opcode_t'(cmd_cur[15:12]);

  assign mv.squares   = cmd_cur[3:0];
  assign mv.head_code = cmd_cur[11:4];

  ////////////////////////////////////////
  // Forward speed ramp
  ////////////////////////////////////////

  assign max_spd = &frwrd[9:8];               // 0x300 and up.
  assign zero    = (frwrd == '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (clr_frwrd)
      frwrd <= '0;                            // Start each ramp from rest.
    else if (heading_rdy) begin
      if (inc_frwrd && !max_spd)
        frwrd <= frwrd + INC_AMT;             // Climb toward top speed.
      else if (dec_frwrd)
        frwrd <= (frwrd < DEC_AMT) ? '0 : frwrd - DEC_AMT; // No wrap below zero.
    end
  end

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state   = state;
    accept      = 1'b0;
    mv.load     = 1'b0;
    clr_cmd_rdy = 1'b0;
    send_resp   = 1'b0;
    strt_cal    = 1'b0;
    moving      = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;

    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;                   // Report calibration done.
          nxt_state = IDLE;
        end
      end

      MOVE: begin
        moving = 1'b1;                        // Turning in place counts.
        if (mv.aligned) begin
          clr_frwrd = 1'b1;
          nxt_state = INCR;
        end
      end

      INCR: begin
        moving    = 1'b1;
        inc_frwrd = 1'b1;
        if (mv.move_done) begin
          fanfare_go = (opcode == FANFARE);   // Tune on the last line.
          nxt_state  = DECR;
        end
      end

      DECR: begin
        dec_frwrd = 1'b1;
        moving    = !zero;                    // Still rolling.
        if (zero) begin
          send_resp = 1'b1;                   // Move complete.
          nxt_state = IDLE;
        end
      end

      default: begin                          // IDLE.
        if (cmd_rdy) begin
          accept      = 1'b1;
          clr_cmd_rdy = 1'b1;                 // Free the command source.
          case (opcode)
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            TOUR: tour_go = 1'b1;             // Stay in IDLE.
            default: begin                    // MOV, FANFARE and unknowns.
              mv.load   = 1'b1;
              nxt_state = MOVE;
            end
          endcase
        end
      end
    endcase
  end

endmodule

//--- knight_cmd_top.sv
// Top level of the knight command processor. Connects the command
// FSM to the heading controller and the line counter through the
// move bundle, and presents the robot signals as plain ports.

module knight_cmd_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [15:0]          cmd,          // Command word from Bluetooth.
  input  logic                 cmd_rdy,      // Command valid.
  input  logic                 cal_done,     // Gyro calibration done.
  input  knight_pkg::heading_t heading,      // Gyro heading.
  input  logic                 heading_rdy,  // Gyro sample strobe.
  input  logic                 lftIR,        // Left edge sensor.
  input  logic                 cntrIR,       // Center line sensor.
  input  logic                 rghtIR,       // Right edge sensor.
  output logic                 clr_cmd_rdy,
  output logic                 send_resp,
  output logic                 strt_cal,
  output logic                 moving,
  output knight_pkg::heading_t error,        // PID error term.
  output knight_pkg::speed_t   frwrd,        // Forward speed.
  output logic                 tour_go,
  output logic                 fanfare_go
);

  ////////////////////////////////////////
  // Move setup and status
  ////////////////////////////////////////

  move_if mv_bus ();

  heading_ctrl heading_ctrl_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .mv      (mv_bus.steer),
    .heading (heading),
    .lftIR   (lftIR),
    .rghtIR  (rghtIR),
    .error   (error)
  );

  line_counter line_counter_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .cntrIR (cntrIR),
    .mv     (mv_bus.counter)
  );

  ////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////

  cmd_sequencer cmd_sequencer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .heading_rdy (heading_rdy),
    .mv          (mv_bus.seq),
    .clr_cmd_rdy (clr_cmd_rdy),
    .send_resp   (send_resp),
    .strt_cal    (strt_cal),
    .moving      (moving),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .frwrd       (frwrd)
  );

endmodule

//--- tb_knight_cmd.sv
// Directed testbench for the knight command processor.
// Runs reset, calibration, tour, heading error, move and fanfare tests,
// each as a task, with expected values worked out from the command rules.
// A summary line and the final verdict close the run.

module tb_knight_cmd;
  timeunit 1ns;
  timeprecision 1ps;
  import knight_pkg::*;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd;
  logic        cmd_rdy;
  logic        cal_done;
  heading_t    heading;
  logic        heading_rdy;
  logic        lftIR;
  logic        cntrIR;
  logic        rghtIR;
  logic        clr_cmd_rdy;
  logic        send_resp;
  logic        strt_cal;
  logic        moving;
  heading_t    error;
  speed_t      frwrd;
  logic        tour_go;
  logic        fanfare_go;

  int          errors = 0;                  // Failed checks.
  int          cnt [6] = '{default: 0};     // High cycles per output.
  int          base_cnt [6];                // Counts at test start.
  string       cnt_name [6] = '{"send_resp", "strt_cal", "clr_cmd_rdy",
                                "tour_go", "fanfare_go", "moving"};
  int          cyc = 0;                     // Cycle index.
  int          fan_cyc = 0;                 // Last fanfare_go cycle.
  int          resp_cyc = 0;                // Last send_resp cycle.
  int          cross_cyc = 0;               // Last cntrIR rise.
  logic        cntr_q = 1'b0;
  logic [31:0] rnd;

  knight_cmd_top knight_cmd_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                  // 8 ns period.
  end

  ////////////////////////////////////////
  // Output activity monitor
  ////////////////////////////////////////

  // Sampled mid-cycle where all outputs have settled.
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (send_resp) begin
      cnt[0]   = cnt[0] + 1;
      resp_cyc = cyc;
    end
    if (strt_cal)    cnt[1] = cnt[1] + 1;
    if (clr_cmd_rdy) cnt[2] = cnt[2] + 1;
    if (tour_go)     cnt[3] = cnt[3] + 1;
    if (fanfare_go) begin
      cnt[4]  = cnt[4] + 1;
      fan_cyc = cyc;
    end
    if (moving)      cnt[5] = cnt[5] + 1;
    if (cntrIR && !cntr_q) cross_cyc = cyc; // Line reached.
    cntr_q = cntrIR;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic compare_value(input string test, input string what,
                               input int exp, input int act);
    assert (exp == act) else begin
      $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
      errors++;
    end
  endtask

  // Negative expectation skips that output.
  task automatic check_counts(input string test, input int e_resp, input int e_cal,
                              input int e_clr, input int e_tour, input int e_fan,
                              input int e_mov);
    int exp_cnt [6];
    exp_cnt = '{e_resp, e_cal, e_clr, e_tour, e_fan, e_mov};
    for (int i = 0; i < 6; i++) begin
      if (exp_cnt[i] >= 0)
        compare_value(test, cnt_name[i], exp_cnt[i], cnt[i] - base_cnt[i]);
    end
  endtask

  // Zero code is north and other codes get the 0xF fill nibble.
  function automatic heading_t target_heading(input head_code_t hc);
    return (hc == 8'h00) ? heading_t'(0) : heading_t'({hc, 4'hF});
  endfunction

  // Leaves the caller at the negedge of the accept cycle.
  task automatic start_cmd(input string test, input opcode_t op, input head_code_t hc,
                           input square_t sq, input heading_t head);
    @(posedge clk);
    cmd     <= {op, hc, sq};
    cmd_rdy <= 1'b1;
    heading <= head;
    @(negedge clk);
    compare_value(test, "clr_cmd_rdy", 1, int'(clr_cmd_rdy)); // Taken at once.
  endtask

  task automatic pulse_heading_rdy();
    @(posedge clk);
    heading_rdy <= 1'b1;
    @(posedge clk);
    heading_rdy <= 1'b0;
    @(negedge clk);                         // Speed updated.
  endtask

  // Aligns, ramps up, crosses 2*sq lines, then ramps down to the response.
  task automatic run_move(input string test, input square_t sq, input int up_ticks,
                          input heading_t head);
    speed_t exp_spd;
    int     guard;
    logic   done;
    exp_spd = '0;
    @(posedge clk);
    heading <= head;                        // Zero error.
    lftIR   <= 1'b0;
    rghtIR  <= 1'b0;
    @(posedge clk);                         // INCR from here.
    repeat (up_ticks) begin
      pulse_heading_rdy();
      if (exp_spd[9:8] != 2'b11)
        exp_spd = exp_spd + INC_AMT;        // Stops once 0x300 is reached.
      compare_value(test, "frwrd up", int'(exp_spd), int'(frwrd));
      compare_value(test, "moving", 1, int'(moving));
      assert (frwrd <= 10'h300) else begin
        $display("%s: forward speed rose above the 0x300 ceiling", test);
        errors++;
      end
    end
    repeat (2 * sq) begin
      @(posedge clk);
      cntrIR <= 1'b1;
      @(posedge clk);
      cntrIR <= 1'b0;
      @(posedge clk);                       // Count settles.
    end
    @(negedge clk);
    done  = send_resp;                      // Already stopped if never ramped.
    guard = 0;
    while (!done && guard < 40) begin
      pulse_heading_rdy();
      exp_spd = (exp_spd > DEC_AMT) ? exp_spd - DEC_AMT : speed_t'(0);
      compare_value(test, "frwrd down", int'(exp_spd), int'(frwrd));
      done  = send_resp;
      guard = guard + 1;
    end
    assert (done) else begin
      $display("%s: timed out waiting for send_resp at the end of the move", test);
      errors++;
    end
    compare_value(test, "moving at stop", 0, int'(moving));
    @(posedge clk);                         // Back to IDLE.
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk);
    compare_value("reset", "control outputs", 0,
                  int'({clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go}));
    compare_value("reset", "frwrd", 0, int'(frwrd));
  endtask

  task automatic test_cal();
    base_cnt = cnt;
    start_cmd("cal", CAL, 8'h00, 4'h0, heading_t'(0));
    compare_value("cal", "strt_cal", 1, int'(strt_cal));
    @(posedge clk);
    cmd_rdy <= 1'b0;
    repeat (4) @(posedge clk);              // Calibration in progress.
    cal_done <= 1'b1;
    @(negedge clk);
    compare_value("cal", "send_resp", 1, int'(send_resp));
    @(posedge clk);
    cal_done <= 1'b0;
    repeat (3) @(posedge clk);
    check_counts("cal", 1, 1, 1, 0, 0, 0);
    compare_value("cal", "frwrd", 0, int'(frwrd));
  endtask

  task automatic test_tour();
    base_cnt = cnt;
    start_cmd("tour", TOUR, 8'h00, 4'h0, heading_t'(0));
    compare_value("tour", "tour_go", 1, int'(tour_go));
    compare_value("tour", "moving", 0, int'(moving));
    @(posedge clk);
    cmd_rdy <= 1'b0;
    repeat (3) @(posedge clk);
    check_counts("tour", 0, 0, 1, 1, 0, 0);
  endtask

  task automatic test_error();
    head_code_t hc;
    heading_t   des;
    heading_t   head;
    heading_t   nud;
    heading_t   exp_err;
    base_cnt = cnt;
    rnd  = $urandom;
    hc   = rnd[7:0];
    des  = target_heading(hc);
    head = des + heading_t'({3'b000, rnd[16:8]}) + 12'sh300; // Far off target.
    start_cmd("error", MOV, hc, 4'h1, head);
    @(posedge clk);
    cmd_rdy <= 1'b0;
    for (int k = 0; k < 4; k++) begin
      @(posedge clk);
      lftIR  <= k[0];
      rghtIR <= k[1];
      @(negedge clk);
      nud     = k[0] ? 12'sh1FF : (k[1] ? -12'sh200 : 12'sh000); // Left has priority.
      exp_err = head - des + nud;
      compare_value("error", "error", int'(exp_err), int'(error));
      compare_value("error", "moving", 1, int'(moving));
    end
    run_move("error", 4'h1, 0, des);
    check_counts("error", 1, 0, 1, 0, 0, -1);
  endtask

  task automatic test_move(input string test, input opcode_t op, input int up_ticks);
    head_code_t hc;
    square_t    sq;
    base_cnt = cnt;
    rnd = $urandom;
    hc  = rnd[7:0];
    sq  = {2'b00, rnd[9:8]} + 4'd1;         // One to four squares.
    start_cmd(test, op, hc, sq, target_heading(hc));
    @(posedge clk);
    cmd_rdy <= 1'b0;
    run_move(test, sq, up_ticks, target_heading(hc));
    check_counts(test, 1, 0, 1, 0, (op == FANFARE) ? 1 : 0, -1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rnd         = $urandom(98);
    rst_n       = 1'b0;
    cmd         = '0;
    cmd_rdy     = 1'b0;
    cal_done    = 1'b0;
    heading     = '0;
    heading_rdy = 1'b0;
    lftIR       = 1'b0;
    cntrIR      = 1'b0;
    rghtIR      = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_cal();
    test_tour();
    test_error();
    test_move("mov_run", MOV, 28);          // Long enough to hit the cap.
    test_move("fanfare", FANFARE, 13);      // Last ramp-down step hits the zero floor.
    assert (cross_cyc < fan_cyc && fan_cyc < resp_cyc) else begin
      $display("fanfare: fanfare_go did not fall between the last crossing and send_resp");
      errors++;
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- src.f
knight_pkg.sv
move_if.sv
heading_ctrl.sv
line_counter.sv
cmd_sequencer.sv
knight_cmd_top.sv
tb_knight_cmd.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_knight_cmd -o sim_knight \
  && ./obj_dir/sim_knight > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
